/* common/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    ////////////////////////////////////////
    // Base opcodes, instruction bits 6..0
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } rv_opcode_e;

    // Immediate layout selector
    typedef enum logic [2:0] {
        FMT_R = 3'd0,
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_U = 3'd3,
        FMT_B = 3'd4,
        FMT_J = 3'd5
    } imm_format_e;

    ////////////////////////////////////////
    // funct3 values for OP and OP_IMM
    ////////////////////////////////////////
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire

/* common/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    // Operation handed to execute
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    ////////////////////////////////////////
    // Packets between the stages
    ////////////////////////////////////////
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_pkt_t;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch;
        logic jump;
        logic alu_src_imm;
        logic pc_src_a;
        logic illegal;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        alu_op_e     alu_op;
        ctrl_t       ctrl;
    } decode_pkt_t;

endpackage

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire logic [31:0]              instr,
    output rv_isa_pkg::imm_format_e       imm_fmt,
    output decode_pkg::alu_op_e           alu_op,
    output decode_pkg::ctrl_t             ctrl
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    // Register and immediate arithmetic share the funct3 map
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    logic [2:0] funct3;
    logic       bit30;
    logic       imm_alt;

    assign funct3 = instr[14:12];
    assign bit30  = instr[30];

    // Bit 30 only selects SRAI among immediate ops
    assign imm_alt = (funct3 == F3_SRL_SRA) && bit30;

    always_comb
    begin
        imm_fmt = FMT_R;
        alu_op  = ALU_ADD;
        ctrl    = '0;
        case (instr[6:0])
            OPC_LUI:
            begin
                imm_fmt          = FMT_U;
                alu_op           = ALU_PASS_B;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OPC_AUIPC:
            begin
                imm_fmt          = FMT_U;
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.pc_src_a    = 1'b1;
            end
            OPC_JAL:
            begin
                imm_fmt          = FMT_J;
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.pc_src_a    = 1'b1;
            end
            OPC_JALR:
            begin
                imm_fmt          = FMT_I;
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm_fmt     = FMT_B;
                alu_op      = ALU_SUB;
                ctrl.branch = 1'b1;
            end
            OPC_LOAD:
            begin
                imm_fmt          = FMT_I;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OPC_STORE:
            begin
                imm_fmt          = FMT_S;
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OPC_OP_IMM:
            begin
                imm_fmt          = FMT_I;
                alu_op           = alu_from_funct(funct3, imm_alt);
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OPC_OP:
            begin
                alu_op         = alu_from_funct(funct3, bit30);
                ctrl.reg_write = 1'b1;
            end
            default:
            begin
                // Includes CSR, fence and system opcodes
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* decode/imm_extender.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_extender (
    input  wire logic [24:0]              imm_bits,
    input  rv_isa_pkg::imm_format_e       imm_fmt,
    output logic [31:0]                   imm
);

    import rv_isa_pkg::*;

    ////////////////////////////////////////
    // imm_bits[n] carries instruction bit n+7
    ////////////////////////////////////////
    logic sign;

    assign sign = imm_bits[24];

    always_comb
    begin
        case (imm_fmt)
            FMT_I:
            begin
                imm = {{20{sign}}, imm_bits[24:13]};
            end
            FMT_S:
            begin
                imm = {{20{sign}}, imm_bits[24:18], imm_bits[4:0]};
            end
            FMT_U:
            begin
                imm = {imm_bits[24:5], 12'b0};
            end
            FMT_B:
            begin
                // Bit 7 of the instruction lands in imm[11]
                imm = {{19{sign}}, sign, imm_bits[0], imm_bits[23:18],
                       imm_bits[4:1], 1'b0};
            end
            FMT_J:
            begin
                // 19..12, then bit 20, then 30..21
                imm = {{11{sign}}, sign, imm_bits[12:5], imm_bits[13],
                       imm_bits[23:14], 1'b0};
            end
            default:
            begin
                imm = 32'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic [4:0]           rs1,
    input  wire logic [4:0]           rs2,
    input  decode_pkg::wb_pkt_t       wb,
    output logic [31:0]               rs1_data,
    output logic [31:0]               rs2_data
);

    import decode_pkg::*;

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.en && (wb.rd != 5'd0))
        begin
            regs[wb.rd] <= wb.data;
        end
    end

    // No bypass, a write shows up after the edge
    assign rs1_data = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

`default_nettype wire

/* source/credit_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
    parameter int DEPTH = 4
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 push,
    input  decode_pkg::fetch_pkt_t    push_pkt,
    input  wire logic                 pop,
    output decode_pkg::fetch_pkt_t    head_pkt,
    output logic                      not_empty,
    output logic                      credit
);

    import decode_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkt_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head_pkt  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    ////////////////////////////////////////
    // Pointers, occupancy and credit pulse
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            // Depth need not be a power of two
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
    parameter int FIFO_DEPTH = 4,
    parameter int EX_CREDITS = 2
) (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 fetch_valid,
    input  decode_pkg::fetch_pkt_t    fetch_pkt,
    input  wire logic                 ex_credit,
    input  decode_pkg::wb_pkt_t       wb,
    output logic                      fetch_credit,
    output logic                      out_valid,
    output decode_pkg::decode_pkt_t   out_pkt
);

    import rv_isa_pkg::*;
    import decode_pkg::*;

    localparam int CRD_W = $clog2(EX_CREDITS + 1);

    fetch_pkt_t       head_pkt;
    logic             not_empty;
    logic             issue;
    logic [CRD_W-1:0] ex_credits;
    imm_format_e      imm_fmt;
    alu_op_e          alu_op;
    ctrl_t            ctrl;
    logic [31:0]      imm;
    logic [31:0]      rs1_data;
    logic [31:0]      rs2_data;
    decode_pkt_t      dec_pkt;

    // Issue needs a packet and a free slot in execute
    assign issue = not_empty && (ex_credits != '0);

    credit_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (fetch_valid),
        .push_pkt  (fetch_pkt),
        .pop       (issue),
        .head_pkt  (head_pkt),
        .not_empty (not_empty),
        .credit    (fetch_credit)
    );

    ////////////////////////////////////////
    // Combinational decode of the head
    ////////////////////////////////////////
    instr_decoder u_dec (
        .instr   (head_pkt.instr),
        .imm_fmt (imm_fmt),
        .alu_op  (alu_op),
        .ctrl    (ctrl)
    );

    imm_extender u_imm (
        .imm_bits (head_pkt.instr[31:7]),
        .imm_fmt  (imm_fmt),
        .imm      (imm)
    );

    reg_file u_rf (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (head_pkt.instr[19:15]),
        .rs2      (head_pkt.instr[24:20]),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_comb
    begin
        dec_pkt.pc       = head_pkt.pc;
        dec_pkt.imm      = imm;
        dec_pkt.rs1_data = rs1_data;
        dec_pkt.rs2_data = rs2_data;
        dec_pkt.rd       = head_pkt.instr[11:7];
        dec_pkt.funct3   = head_pkt.instr[14:12];
        dec_pkt.alu_op   = alu_op;
        dec_pkt.ctrl     = ctrl;
    end

    ////////////////////////////////////////
    // Execute credits and output register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ex_credits <= CRD_W'(EX_CREDITS);
            out_valid  <= 1'b0;
        end
        else
        begin
            // Return and spend together cancel out
            case ({issue, ex_credit})
                2'b10:   ex_credits <= ex_credits - 1'b1;
                2'b01:   ex_credits <= ex_credits + 1'b1;
                default: ex_credits <= ex_credits;
            endcase
            out_valid <= issue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            out_pkt <= dec_pkt;
        end
    end

endmodule

`default_nettype wire

/* bench/decode_stage_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage_checker #(
    parameter int DEPTH   = 4,
    parameter int CREDITS = 2
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic push,
    input  wire logic pop,
    input  wire logic ex_credit,
    input  wire logic out_valid,
    input  wire logic fetch_credit
);

    // Shadow fill level of the input buffer
    int occupancy;
    // Shadow of the execute credit count
    int ex_count;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            occupancy <= 0;
            ex_count  <= CREDITS;
        end
        else
        begin
            occupancy <= occupancy + (push ? 1 : 0) - (pop ? 1 : 0);
            ex_count  <= ex_count - (pop ? 1 : 0) + (ex_credit ? 1 : 0);
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> (occupancy < DEPTH))
        else $error("push into a full input buffer");

    no_issue_without_credit: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> (ex_count > 0))
        else $error("issue with a zero execute credit count");

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!out_valid && !fetch_credit))
        else $error("out_valid or fetch_credit high while in reset");

endmodule

bind decode_stage decode_stage_checker #(
    .DEPTH   (FIFO_DEPTH),
    .CREDITS (EX_CREDITS)
) u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .push         (fetch_valid),
    .pop          (issue),
    .ex_credit    (ex_credit),
    .out_valid    (out_valid),
    .fetch_credit (fetch_credit)
);

`default_nettype wire

/* bench/decode_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb;

    import rv_isa_pkg::*;
    import decode_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int EX_CREDITS  = 2;
    localparam int BP_PKTS     = FIFO_DEPTH + EX_CREDITS + 2;
    localparam int TOTAL_PKTS  = 60 + 43 + 24 + BP_PKTS + 64 + 4 + 2;
    localparam int CYCLE_LIMIT = 4 * TOTAL_PKTS + 200;

    bit          clk;
    logic        arst_n;
    logic        fetch_valid;
    fetch_pkt_t  fetch_pkt;
    logic        ex_credit;
    wb_pkt_t     wb;
    logic        fetch_credit;
    logic        out_valid;
    decode_pkt_t out_pkt;

    int          seed = 32'h5e473033;
    logic [31:0] model_regs [32];
    fetch_pkt_t  send_q [$];
    decode_pkt_t exp_q [$];
    wb_pkt_t     wb_q [$];
    logic [31:0] next_pc;
    int          fetch_credits;
    int          ex_pending;
    int          sent_total;
    int          issued_total;
    int          credit_total;
    int          cycles;
    int          errors;
    int          err_base;
    int          tests_passed;
    int          tests_failed;
    int          rst_hold;
    int          post_rst;
    bit          fetch_random;
    bit          ret_random;
    bit          ret_enable;

    rv_opcode_e fmt_opcs [6] = '{OPC_OP_IMM, OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_JAL, OPC_OP};
    rv_opcode_e all_opcs [9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                 OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};

    decode_stage #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .EX_CREDITS (EX_CREDITS)
    ) dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .fetch_pkt    (fetch_pkt),
        .ex_credit    (ex_credit),
        .wb           (wb),
        .fetch_credit (fetch_credit),
        .out_valid    (out_valid),
        .out_pkt      (out_pkt)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic decode_pkt_t decode_ref(input fetch_pkt_t p, input logic [31:0] regs [32]);
        decode_pkt_t d;
        logic [31:0] i;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        i          = p.instr;
        imm_i      = {{20{i[31]}}, i[31:20]};
        imm_s      = {{20{i[31]}}, i[31:25], i[11:7]};
        imm_b      = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        imm_u      = {i[31:12], 12'b0};
        imm_j      = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        d.pc       = p.pc;
        d.imm      = 32'b0;
        d.rs1_data = regs[i[19:15]];
        d.rs2_data = regs[i[24:20]];
        d.rd       = i[11:7];
        d.funct3   = i[14:12];
        d.alu_op   = ALU_ADD;
        // Flags msb first from reg_write down to illegal
        case (i[6:0])
            OPC_LUI:
            begin
                d.imm    = imm_u;
                d.alu_op = ALU_PASS_B;
                d.ctrl   = 8'b1000_0100;
            end
            OPC_AUIPC:
            begin
                d.imm  = imm_u;
                d.ctrl = 8'b1000_0110;
            end
            OPC_JAL:
            begin
                d.imm  = imm_j;
                d.ctrl = 8'b1000_1110;
            end
            OPC_JALR:
            begin
                d.imm  = imm_i;
                d.ctrl = 8'b1000_1100;
            end
            OPC_BRANCH:
            begin
                d.imm    = imm_b;
                d.alu_op = ALU_SUB;
                d.ctrl   = 8'b0001_0000;
            end
            OPC_LOAD:
            begin
                d.imm  = imm_i;
                d.ctrl = 8'b1100_0100;
            end
            OPC_STORE:
            begin
                d.imm  = imm_s;
                d.ctrl = 8'b0010_0100;
            end
            OPC_OP_IMM:
            begin
                d.imm    = imm_i;
                d.alu_op = alu_ref(i[14:12], (i[14:12] == 3'b101) && i[30]);
                d.ctrl   = 8'b1000_0100;
            end
            OPC_OP:
            begin
                d.alu_op = alu_ref(i[14:12], i[30]);
                d.ctrl   = 8'b1000_0000;
            end
            default:
            begin
                d.ctrl = 8'b0000_0001;
            end
        endcase
        return d;
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] opc, input logic sign);
        logic [31:0] r;
        r       = $random(seed);
        r[6:0]  = opc;
        r[31]   = sign;
        return r;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic field_error(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("error: out_pkt.%s expected %h got %h", name, exp, got);
        errors++;
    endtask

    task automatic compare_pkt(input decode_pkt_t got, input decode_pkt_t exp);
        if (got.pc !== exp.pc)
            field_error("pc", got.pc, exp.pc);
        if (got.imm !== exp.imm)
            field_error("imm", got.imm, exp.imm);
        if (got.rs1_data !== exp.rs1_data)
            field_error("rs1_data", got.rs1_data, exp.rs1_data);
        if (got.rs2_data !== exp.rs2_data)
            field_error("rs2_data", got.rs2_data, exp.rs2_data);
        if (got.rd !== exp.rd)
            field_error("rd", 32'(got.rd), 32'(exp.rd));
        if (got.funct3 !== exp.funct3)
            field_error("funct3", 32'(got.funct3), 32'(exp.funct3));
        if (got.alu_op !== exp.alu_op)
            field_error("alu_op", 32'(got.alu_op), 32'(exp.alu_op));
        if (got.ctrl !== exp.ctrl)
            field_error("ctrl", 32'(got.ctrl), 32'(exp.ctrl));
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Falling edge: sample, compare, drive
    ////////////////////////////////////////
    always @(negedge clk)
    begin
        decode_pkt_t exp_pkt;
        if ((!arst_n || post_rst > 0) && (out_valid || fetch_credit))
        begin
            $display("out_valid or fetch_credit was high during or right after reset");
            errors++;
        end
        if (out_valid)
        begin
            issued_total++;
            ex_pending++;
            if (exp_q.size() == 0)
            begin
                $display("a packet was issued although none was expected");
                errors++;
            end
            else
            begin
                exp_pkt = exp_q.pop_front();
                compare_pkt(out_pkt, exp_pkt);
            end
        end
        if (fetch_credit)
        begin
            credit_total++;
            fetch_credits++;
        end
        // Reset sequencing
        if (rst_hold > 0)
        begin
            arst_n        = 1'b0;
            rst_hold      = rst_hold - 1;
            fetch_credits = FIFO_DEPTH;
            ex_pending    = 0;
            model_regs    = '{default: '0};
            // Packets in flight are lost with the reset
            send_q.delete();
            exp_q.delete();
        end
        else if (!arst_n)
        begin
            arst_n   = 1'b1;
            post_rst = 2;
        end
        else if (post_rst > 0)
        begin
            post_rst = post_rst - 1;
        end
        fetch_valid = 1'b0;
        ex_credit   = 1'b0;
        wb          = '0;
        if (arst_n && post_rst == 0)
        begin
            if (wb_q.size() > 0)
                wb = wb_q.pop_front();
            if (send_q.size() > 0 && fetch_credits > 0 &&
                (!fetch_random || (($random(seed) & 1) != 0)))
            begin
                fetch_pkt     = send_q.pop_front();
                fetch_valid   = 1'b1;
                fetch_credits = fetch_credits - 1;
                sent_total++;
            end
            if (ex_pending > 0 && ret_enable && (!ret_random || (($random(seed) & 1) != 0)))
            begin
                ex_credit  = 1'b1;
                ex_pending = ex_pending - 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Sequencing helpers
    ////////////////////////////////////////
    task automatic send_instr(input logic [31:0] instr);
        fetch_pkt_t p;
        p.pc    = next_pc;
        p.instr = instr;
        next_pc = next_pc + 32'd4;
        send_q.push_back(p);
        exp_q.push_back(decode_ref(p, model_regs));
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        wb_pkt_t w;
        w.en   = 1'b1;
        w.rd   = rd;
        w.data = data;
        wb_q.push_back(w);
        if (rd != 5'd0)
            model_regs[rd] = data;
        while (wb_q.size() > 0)
            @(posedge clk);
    endtask

    // Idle means all sent, all issued and every credit back home
    task automatic drain();
        while (send_q.size() > 0 || exp_q.size() > 0 || ex_pending > 0 ||
               fetch_credits != FIFO_DEPTH)
            @(posedge clk);
    endtask

    task automatic apply_reset();
        rst_hold = 8;
        @(posedge clk);
        while (rst_hold > 0 || !arst_n || post_rst > 0)
            @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (errors == err_base)
        begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    initial
    begin
        int base_sent;
        int base_issued;
        int base_credit;
        logic [31:0] r;
        arst_n      = 1'b0;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        ex_credit   = 1'b0;
        wb          = '0;
        model_regs  = '{default: '0};
        next_pc     = 32'h0000_1000;
        fetch_credits = FIFO_DEPTH;
        ret_enable  = 1'b1;
        rst_hold    = 8;
        apply_reset();

        // Immediates for each format, both signs
        for (int k = 0; k < 60; k++)
            send_instr(make_instr(fmt_opcs[3'(k % 6)], 1'((k / 6) % 2)));
        drain();
        end_test("immediates");

        for (int k = 2; k < 9; k++)
            send_instr(make_instr(all_opcs[4'(k - 2)], 1'($random(seed))));
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int alt = 0; alt < 2; alt++)
            begin
                r        = make_instr(OPC_OP, 1'($random(seed)));
                r[14:12] = 3'(f3);
                r[30]    = 1'(alt);
                send_instr(r);
                r[6:0]   = OPC_OP_IMM;
                send_instr(r);
            end
        end
        send_instr(make_instr(7'b1110011, 1'b0));
        send_instr(make_instr(7'b0001111, 1'b1));
        send_instr(make_instr(7'b0000000, 1'b0));
        send_instr(make_instr(7'b1111111, 1'b1));
        drain();
        end_test("control decode");

        write_reg(5'd0, 32'hdead_beef);
        for (int k = 0; k < 15; k++)
            write_reg(5'($random(seed)), $random(seed));
        for (int k = 0; k < 24; k++)
        begin
            r = make_instr(OPC_OP, 1'($random(seed)));
            if (k < 4)
                r[19:15] = 5'd0;
            send_instr(r);
        end
        drain();
        end_test("register reads");

        ////////////////////////////////////////
        // Execute back-pressure
        ////////////////////////////////////////
        ret_enable  = 1'b0;
        base_sent   = sent_total;
        base_issued = issued_total;
        base_credit = credit_total;
        for (int k = 0; k < BP_PKTS; k++)
            send_instr(make_instr(OPC_OP_IMM, 1'($random(seed))));
        while (sent_total - base_sent < FIFO_DEPTH + EX_CREDITS)
            @(posedge clk);
        // Window long enough to see a leak past the stall
        repeat (8) @(posedge clk);
        compare_count("issued while stalled", issued_total - base_issued, EX_CREDITS);
        compare_count("fetch credits while stalled", credit_total - base_credit, EX_CREDITS);
        compare_count("accepted while stalled", sent_total - base_sent, FIFO_DEPTH + EX_CREDITS);
        ret_enable = 1'b1;
        drain();
        compare_count("issued after release", issued_total - base_issued, BP_PKTS);
        end_test("back-pressure");

        fetch_random = 1'b1;
        ret_random   = 1'b1;
        base_sent    = sent_total;
        base_issued  = issued_total;
        base_credit  = credit_total;
        for (int k = 0; k < 64; k++)
            send_instr(make_instr(all_opcs[4'($unsigned($random(seed)) % 9)], 1'($random(seed))));
        drain();
        compare_count("fetch credit pulses", credit_total - base_credit, sent_total - base_sent);
        compare_count("issued packets", issued_total - base_issued, 64);
        fetch_random = 1'b0;
        ret_random   = 1'b0;
        end_test("random credits");

        write_reg(5'd5, $random(seed) | 32'h1);
        write_reg(5'd9, $random(seed) | 32'h1);
        // Reset lands while packets are still issuing
        base_issued = issued_total;
        for (int k = 0; k < 4; k++)
            send_instr(make_instr(OPC_LOAD, 1'($random(seed))));
        while (issued_total == base_issued)
            @(posedge clk);
        apply_reset();
        r        = make_instr(OPC_OP, 1'b0);
        r[19:15] = 5'd5;
        r[24:20] = 5'd9;
        send_instr(r);
        r        = make_instr(OPC_STORE, 1'b1);
        r[19:15] = 5'd9;
        r[24:20] = 5'd5;
        send_instr(r);
        drain();
        end_test("reset state");

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
common/rv_isa_pkg.sv
common/decode_pkg.sv
decode/instr_decoder.sv
decode/imm_extender.sv
decode/reg_file.sv
source/credit_fifo.sv
source/decode_stage.sv
bench/decode_stage_checker.sv
bench/decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module decode_stage_tb -f build.f || exit 1
result=$(./obj_dir/Vdecode_stage_tb)
echo "$result"
echo "$result" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1
